/* Makefile */
# Verilator build and run of the control-transfer trace testbench

VERILATOR ?= verilator
TOP ?= tb_ctm
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* flist.f */
hdl/ctm_pkg.sv
hdl/ctm_event_if.sv
hdl/ctm_config_regs.sv
hdl/ctm_sample.sv
hdl/ctm_trace_buffer.sv
hdl/ctm_packetizer.sv
hdl/ctm_top.sv
tests/tb_ctm.sv

/* hdl/ctm_config_regs.sv */
// trace configuration registers with strobe write and one-cycle read answer
`timescale 1ns/1ps

module ctm_config_regs (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               reg_wr,
   input  logic               reg_rd,
   input  logic [1:0]         reg_addr,
   input  ctm_pkg::flit_t     reg_wdata,
   output logic               reg_rvalid,
   output logic               reg_err,
   output ctm_pkg::flit_t     reg_rdata,
   output logic               enable,
   output ctm_pkg::node_id_t  dest
);

   // writable registers, read-only and unknown addresses are ignored
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         enable <= 1'b0;
         dest <= '0;
      end else if (reg_wr) begin
         case (reg_addr)
            ctm_pkg::REG_ENABLE: enable <= reg_wdata[0];
            ctm_pkg::REG_DEST: dest <= reg_wdata;
            default: ;
         endcase
      end
   end

   // read answer strobe and error flag
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         reg_rvalid <= 1'b0;
         reg_err <= 1'b0;
      end else begin
         reg_rvalid <= reg_rd;
         reg_err <= reg_rd && (reg_addr == 2'd3);
      end
   end

   // read data, only sampled while the strobe is high
   always_ff @(posedge clk) begin
      if (reg_rd) begin
         case (reg_addr)
            ctm_pkg::REG_ENABLE: reg_rdata <= ctm_pkg::flit_t'(enable);
            ctm_pkg::REG_DEST: reg_rdata <= dest;
            ctm_pkg::REG_ADDR_WIDTH: reg_rdata <= ctm_pkg::flit_t'(ctm_pkg::ADDR_W);
            default: reg_rdata <= '0;
         endcase
      end
   end

endmodule

/* hdl/ctm_event_if.sv */
// trace event interface between the sample, buffer and packetizer stages
`timescale 1ns/1ps

interface ctm_event_if;

   // valid is a single-cycle strobe, fields only hold while it is high
   logic valid;
   logic prvchange;
   logic jal;
   logic jalr;
   ctm_pkg::prv_t prv;
   ctm_pkg::addr_t pc;
   ctm_pkg::addr_t npc;
   ctm_pkg::time_t timestamp;

   modport src (
      output valid, prvchange, jal, jalr, prv, pc, npc, timestamp
   );

   modport dst (
      input valid, prvchange, jal, jalr, prv, pc, npc, timestamp
   );

endinterface

/* hdl/ctm_packetizer.sv */
// packetizer stage, sends one trace event as a fixed nine-flit packet
`timescale 1ns/1ps

module ctm_packetizer (
   input  logic               clk,
   input  logic               arst_n,
   ctm_event_if.dst           ev,
   input  ctm_pkg::ovf_cnt_t  ovf_count,
   input  ctm_pkg::node_id_t  id,
   input  ctm_pkg::node_id_t  dest,
   output logic               busy,
   output logic               flit_valid,
   output logic               flit_last,
   output ctm_pkg::flit_t     flit_data
);

   ctm_pkg::pkt_state_t            state;
   logic [ctm_pkg::FLIT_IDX_W-1:0] flit_idx;
   logic                           last_idx;

   // latched packet content
   ctm_pkg::node_id_t              dest_q;
   ctm_pkg::ovf_cnt_t              ovf_q;
   logic                           prvchange_q;
   logic                           jal_q;
   logic                           jalr_q;
   ctm_pkg::prv_t                  prv_q;
   ctm_pkg::addr_t                 pc_q;
   ctm_pkg::addr_t                 npc_q;
   ctm_pkg::time_t                 ts_q;

   assign last_idx = (flit_idx == ctm_pkg::FLIT_IDX_W'(ctm_pkg::PKT_FLITS - 1));

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= ctm_pkg::PKT_IDLE;
         flit_idx <= '0;
      end else begin
         case (state)
            ctm_pkg::PKT_IDLE: begin
               flit_idx <= '0;
               if (ev.valid) state <= ctm_pkg::PKT_SEND;
            end
            ctm_pkg::PKT_SEND: begin
               flit_idx <= flit_idx + 1'b1;
               if (last_idx) state <= ctm_pkg::PKT_IDLE;
            end
            default: state <= ctm_pkg::PKT_IDLE;
         endcase
      end
   end

   // the buffer only strobes while we are idle
   always_ff @(posedge clk) begin
      if (ev.valid && (state == ctm_pkg::PKT_IDLE)) begin
         dest_q <= dest;
         ovf_q <= ovf_count;
         prvchange_q <= ev.prvchange;
         jal_q <= ev.jal;
         jalr_q <= ev.jalr;
         prv_q <= ev.prv;
         pc_q <= ev.pc;
         npc_q <= ev.npc;
         ts_q <= ev.timestamp;
      end
   end

   assign busy = (state == ctm_pkg::PKT_SEND);
   assign flit_valid = busy;
   assign flit_last = busy && last_idx;

   always_comb begin
      case (flit_idx)
         4'd0: flit_data = dest_q;
         4'd1: flit_data = id;
         4'd2: flit_data = {ovf_q, prvchange_q, jal_q, jalr_q, prv_q, 3'b000};
         4'd3: flit_data = ts_q[15:0];
         4'd4: flit_data = ts_q[31:16];
         4'd5: flit_data = pc_q[15:0];
         4'd6: flit_data = pc_q[31:16];
         4'd7: flit_data = npc_q[15:0];
         4'd8: flit_data = npc_q[31:16];
         default: flit_data = '0;
      endcase
   end

endmodule

/* hdl/ctm_pkg.sv */
// control-transfer trace package with trace widths, flit format and register map
package ctm_pkg;

   // fixed trace widths
   localparam int ADDR_W = 32;
   localparam int TIME_W = 32;
   localparam int PRV_W = 2;
   localparam int FLIT_W = 16;
   localparam int NODE_ID_W = 16;
   localparam int OVF_W = 8;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [TIME_W-1:0] time_t;
   typedef logic [PRV_W-1:0] prv_t;
   typedef logic [FLIT_W-1:0] flit_t;
   typedef logic [NODE_ID_W-1:0] node_id_t;
   typedef logic [OVF_W-1:0] ovf_cnt_t;

   // event queue
   localparam int BUF_DEPTH = 4;
   localparam int BUF_PTR_W = $clog2(BUF_DEPTH);

   // packet format, nine flits per event
   localparam int PKT_FLITS = 9;
   localparam int FLIT_IDX_W = $clog2(PKT_FLITS);

   // machine mode after reset
   localparam prv_t PRV_RESET = 2'd3;

   // register map
   localparam logic [1:0] REG_ENABLE = 2'd0;
   localparam logic [1:0] REG_DEST = 2'd1;
   localparam logic [1:0] REG_ADDR_WIDTH = 2'd2;

   typedef enum logic {
      PKT_IDLE,
      PKT_SEND
   } pkt_state_t;

endpackage

/* hdl/ctm_sample.sv */
// trace sample stage, detects jumps and privilege changes and timestamps them
`timescale 1ns/1ps

module ctm_sample (
   input  logic            clk,
   input  logic            arst_n,
   input  logic            enable,
   input  logic            trace_valid,
   input  logic            trace_jal,
   input  logic            trace_jalr,
   input  logic            trace_mem,
   input  ctm_pkg::addr_t  trace_pc,
   input  ctm_pkg::addr_t  trace_npc,
   input  ctm_pkg::prv_t   trace_prv,
   ctm_event_if.src        ev
);

   ctm_pkg::time_t ts_cnt;
   ctm_pkg::prv_t  prv_last;
   logic           prv_diff;
   logic           jump;
   logic           qualify;

   assign prv_diff = (trace_prv != prv_last);
   assign jump = (trace_jal || trace_jalr) && !trace_mem;
   assign qualify = trace_valid && enable && (prv_diff || jump);

   // free-running cycle count, zero in the first cycle out of reset
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ts_cnt <= '0;
      end else begin
         ts_cnt <= ts_cnt + 1'b1;
      end
   end

   // privilege of the last valid entry, tracked even while disabled
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         prv_last <= ctm_pkg::PRV_RESET;
      end else if (trace_valid) begin
         prv_last <= trace_prv;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ev.valid <= 1'b0;
      end else begin
         ev.valid <= qualify;
      end
   end

   // event payload, timestamp is the count of the trace cycle
   always_ff @(posedge clk) begin
      if (qualify) begin
         ev.prvchange <= prv_diff;
         ev.jal <= trace_jal;
         ev.jalr <= trace_jalr;
         ev.prv <= trace_prv;
         ev.pc <= trace_pc;
         ev.npc <= trace_npc;
         ev.timestamp <= ts_cnt;
      end
   end

endmodule

/* hdl/ctm_top.sv */
// control-transfer trace module top level, registers plus the three-stage pipeline
`timescale 1ns/1ps

module ctm_top (
   input  logic               clk,
   input  logic               arst_n,
   input  ctm_pkg::node_id_t  id,
   // retired-instruction trace
   input  logic               trace_valid,
   input  ctm_pkg::addr_t     trace_pc,
   input  ctm_pkg::addr_t     trace_npc,
   input  logic               trace_jal,
   input  logic               trace_jalr,
   input  logic               trace_mem,
   input  ctm_pkg::prv_t      trace_prv,
   // register port
   input  logic               reg_wr,
   input  logic               reg_rd,
   input  logic [1:0]         reg_addr,
   input  ctm_pkg::flit_t     reg_wdata,
   output logic               reg_rvalid,
   output ctm_pkg::flit_t     reg_rdata,
   output logic               reg_err,
   // debug flits
   output logic               flit_valid,
   output ctm_pkg::flit_t     flit_data,
   output logic               flit_last
);

   logic              enable;
   ctm_pkg::node_id_t dest;
   logic              busy;
   ctm_pkg::ovf_cnt_t ovf_count;

   ctm_event_if sample_ev ();
   ctm_event_if buf_ev ();

   ctm_config_regs config_regs_inst (
      .clk, .arst_n, .reg_wr, .reg_rd, .reg_addr, .reg_wdata,
      .reg_rvalid, .reg_err, .reg_rdata, .enable, .dest
   );

   ctm_sample sample_inst (
      .clk, .arst_n, .enable, .trace_valid, .trace_jal, .trace_jalr, .trace_mem,
      .trace_pc, .trace_npc, .trace_prv, .ev(sample_ev.src)
   );

   ctm_trace_buffer trace_buffer_inst (
      .clk, .arst_n, .ev_in(sample_ev.dst), .ev_out(buf_ev.src), .busy, .ovf_count
   );

   ctm_packetizer packetizer_inst (
      .clk, .arst_n, .ev(buf_ev.dst), .ovf_count, .id, .dest, .busy,
      .flit_valid, .flit_last, .flit_data
   );

endmodule

/* hdl/ctm_trace_buffer.sv */
// trace buffer stage, small event queue with a saturating drop counter
`timescale 1ns/1ps

module ctm_trace_buffer (
   input  logic               clk,
   input  logic               arst_n,
   ctm_event_if.dst           ev_in,
   ctm_event_if.src           ev_out,
   input  logic               busy,
   output ctm_pkg::ovf_cnt_t  ovf_count
);

   logic                          prvchange_mem [ctm_pkg::BUF_DEPTH];
   logic                          jal_mem [ctm_pkg::BUF_DEPTH];
   logic                          jalr_mem [ctm_pkg::BUF_DEPTH];
   ctm_pkg::prv_t                 prv_mem [ctm_pkg::BUF_DEPTH];
   ctm_pkg::addr_t                pc_mem [ctm_pkg::BUF_DEPTH];
   ctm_pkg::addr_t                npc_mem [ctm_pkg::BUF_DEPTH];
   ctm_pkg::time_t                ts_mem [ctm_pkg::BUF_DEPTH];

   logic [ctm_pkg::BUF_PTR_W-1:0] wr_ptr;
   logic [ctm_pkg::BUF_PTR_W-1:0] rd_ptr;
   logic [ctm_pkg::BUF_PTR_W:0]   count;
   logic                          full;
   logic                          send;
   logic                          wr_en;
   logic                          drop;

   assign full = (count == (ctm_pkg::BUF_PTR_W + 1)'(ctm_pkg::BUF_DEPTH));
   assign send = (count != '0) && !busy;
   // a send frees the head slot, so a full queue still takes the write
   assign wr_en = ev_in.valid && (!full || send);
   assign drop = ev_in.valid && !wr_en;

   // head event goes out combinationally
   assign ev_out.valid = send;
   assign ev_out.prvchange = prvchange_mem[rd_ptr];
   assign ev_out.jal = jal_mem[rd_ptr];
   assign ev_out.jalr = jalr_mem[rd_ptr];
   assign ev_out.prv = prv_mem[rd_ptr];
   assign ev_out.pc = pc_mem[rd_ptr];
   assign ev_out.npc = npc_mem[rd_ptr];
   assign ev_out.timestamp = ts_mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         prvchange_mem[wr_ptr] <= ev_in.prvchange;
         jal_mem[wr_ptr] <= ev_in.jal;
         jalr_mem[wr_ptr] <= ev_in.jalr;
         prv_mem[wr_ptr] <= ev_in.prv;
         pc_mem[wr_ptr] <= ev_in.pc;
         npc_mem[wr_ptr] <= ev_in.npc;
         ts_mem[wr_ptr] <= ev_in.timestamp;
      end
   end

   // pointers wrap naturally, depth is a power of two
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         if (wr_en) wr_ptr <= wr_ptr + 1'b1;
         if (send) rd_ptr <= rd_ptr + 1'b1;
         count <= count + wr_en - send;
      end
   end

   // drops saturate at the top, cleared as the packetizer takes the count
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ovf_count <= '0;
      end else if (send) begin
         ovf_count <= '0;
      end else if (drop && (ovf_count != '1)) begin
         ovf_count <= ovf_count + 1'b1;
      end
   end

endmodule

/* tests/tb_ctm.sv */
// testbench for the control-transfer trace module against a packet reference model
`timescale 1ns/1ps

module tb_ctm;

   localparam int N_BURST = 12;
   localparam int N_RANDOM = 300;
   localparam int N_ENTRIES = 12 + N_BURST + N_RANDOM;
   localparam int TIMEOUT_CYCLES = 40 * N_ENTRIES + 1000;
   localparam ctm_pkg::node_id_t SRC_ID = 16'h5a3c;

   typedef logic [ctm_pkg::PKT_FLITS*16-1:0] pkt_t;

   logic               clk;
   logic               arst_n;
   ctm_pkg::node_id_t  id;
   logic               trace_valid;
   ctm_pkg::addr_t     trace_pc;
   ctm_pkg::addr_t     trace_npc;
   logic               trace_jal;
   logic               trace_jalr;
   logic               trace_mem;
   ctm_pkg::prv_t      trace_prv;
   logic               reg_wr;
   logic               reg_rd;
   logic [1:0]         reg_addr;
   ctm_pkg::flit_t     reg_wdata;
   logic               reg_rvalid;
   ctm_pkg::flit_t     reg_rdata;
   logic               reg_err;
   logic               flit_valid;
   ctm_pkg::flit_t     flit_data;
   logic               flit_last;

   // reference model state
   ctm_pkg::time_t     cyc;
   logic               enable_m;
   ctm_pkg::node_id_t  dest_m;
   ctm_pkg::prv_t      prv_exp;
   pkt_t               exp_q[$];

   // compare state
   pkt_t               rx_pkt;
   pkt_t               masked;
   int                 rx_idx = 0;
   int                 match;
   int                 head = 0;
   int                 rx_count = 0;
   int                 skipped_total = 0;
   int                 reported_total = 0;

   ctm_top ctm_top_inst (.*);

   always #2 clk = ~clk;

   // cycles since reset release give the expected timestamp
   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cyc <= '0;
      end else begin
         cyc <= cyc + 1;
      end
   end

   task automatic abort(input string why);
      $display("%s", why);
      $display("TEST RESULT: FAIL");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
         input logic [63:0] exp);
      if (got !== exp) begin
         $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
         abort("value mismatch");
      end
   endtask

   // expected nine flits of one event with the drop count field left at zero
   function automatic pkt_t build_packet(input ctm_pkg::node_id_t dst, input logic chg,
         input logic j, input logic jr, input ctm_pkg::prv_t p, input ctm_pkg::addr_t pc,
         input ctm_pkg::addr_t npc, input ctm_pkg::time_t ts);
      pkt_t pkt;
      pkt[0 +: 16] = dst;
      pkt[16 +: 16] = SRC_ID;
      pkt[32 +: 16] = {8'h00, chg, j, jr, p, 3'b000};
      // two-flit fields go low half first
      pkt[48 +: 32] = ts;
      pkt[80 +: 32] = pc;
      pkt[112 +: 32] = npc;
      return pkt;
   endfunction

   // one retired instruction held for a single cycle from a falling edge
   task automatic drive_entry(input logic j, input logic jr, input logic mem,
         input ctm_pkg::prv_t p, input ctm_pkg::addr_t pc, input ctm_pkg::addr_t npc);
      logic chg;
      chg = (p != prv_exp);
      trace_valid = 1'b1;
      trace_jal = j;
      trace_jalr = jr;
      trace_mem = mem;
      trace_prv = p;
      trace_pc = pc;
      trace_npc = npc;
      if (enable_m && (chg || ((j || jr) && !mem))) begin
         exp_q.push_back(build_packet(dest_m, chg, j, jr, p, pc, npc, cyc));
      end
      // privilege is tracked on every entry whether traced or not
      prv_exp = p;
      @(negedge clk);
      trace_valid = 1'b0;
   endtask

   task automatic write_reg(input logic [1:0] addr, input ctm_pkg::flit_t data);
      reg_wr = 1'b1;
      reg_addr = addr;
      reg_wdata = data;
      @(negedge clk);
      reg_wr = 1'b0;
   endtask

   // the answer is due exactly one cycle after the read strobe
   task automatic read_check(input logic [1:0] addr, input ctm_pkg::flit_t exp_data,
         input logic exp_err);
      reg_rd = 1'b1;
      reg_addr = addr;
      @(negedge clk);
      reg_rd = 1'b0;
      check_value("reg_rvalid", reg_rvalid, 1'b1);
      check_value("reg_err", reg_err, exp_err);
      if (!exp_err) begin
         check_value("reg_rdata", reg_rdata, exp_data);
      end
   endtask

   // packets are at most one idle cycle apart while the buffer holds events
   task automatic wait_quiet();
      int quiet;
      quiet = 0;
      while (quiet < 20) begin
         @(negedge clk);
         quiet = flit_valid ? 0 : quiet + 1;
      end
   endtask

   // collect each packet and match it in order against the expected queue
   always @(negedge clk) begin
      if (arst_n && flit_valid) begin
         rx_pkt[rx_idx*16 +: 16] = flit_data;
         rx_idx = rx_idx + 1;
         if (flit_last) begin
            check_value("flit count", rx_idx, ctm_pkg::PKT_FLITS);
            masked = rx_pkt;
            masked[40 +: 8] = 8'h00;
            match = head;
            while (match < exp_q.size() && exp_q[match] !== masked) begin
               match = match + 1;
            end
            if (match == exp_q.size()) begin
               abort("received packet matches no expected packet");
            end else begin
               // drops are reported by the packet sent first after them
               skipped_total = skipped_total + (match - head);
               reported_total = reported_total + int'(rx_pkt[40 +: 8]);
               rx_count = rx_count + 1;
               head = match + 1;
               rx_idx = 0;
               if (skipped_total > reported_total) begin
                  abort("more packets went missing than the drop counts report");
               end
            end
         end
      end
   end

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      abort("watchdog timeout, the tests did not finish in time");
   end

   initial begin
      int rx0;
      int rep0;
      ctm_pkg::prv_t p;
      ctm_pkg::node_id_t dst;
      void'($urandom(32'h6669_b62c));
      clk = 1'b0;
      arst_n = 1'b0;
      id = SRC_ID;
      trace_valid = 1'b0;
      trace_pc = '0;
      trace_npc = '0;
      trace_jal = 1'b0;
      trace_jalr = 1'b0;
      trace_mem = 1'b0;
      trace_prv = ctm_pkg::PRV_RESET;
      reg_wr = 1'b0;
      reg_rd = 1'b0;
      reg_addr = '0;
      reg_wdata = '0;
      enable_m = 1'b0;
      dest_m = '0;
      prv_exp = ctm_pkg::PRV_RESET;
      repeat (5) @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);

      // reset values and then jumps with tracing still off
      read_check(ctm_pkg::REG_ENABLE, 16'd0, 1'b0);
      read_check(ctm_pkg::REG_DEST, 16'd0, 1'b0);
      read_check(ctm_pkg::REG_ADDR_WIDTH, 16'd32, 1'b0);
      read_check(2'd3, 16'd0, 1'b1);
      drive_entry(1'b1, 1'b0, 1'b0, 2'd3, $urandom(), $urandom());
      drive_entry(1'b0, 1'b1, 1'b0, 2'd3, $urandom(), $urandom());
      drive_entry(1'b1, 1'b0, 1'b0, 2'd3, $urandom(), $urandom());
      wait_quiet();
      check_value("flits while disabled", rx_idx, 0);

      dst = ctm_pkg::node_id_t'($urandom_range(1, 16'hffff));
      write_reg(ctm_pkg::REG_DEST, dst);
      dest_m = dst;
      write_reg(ctm_pkg::REG_ENABLE, 16'd1);
      enable_m = 1'b1;
      read_check(ctm_pkg::REG_DEST, dst, 1'b0);

      // single spaced entries of jal, jalr, jal, jal with mem, plain and jalr
      rx0 = rx_count;
      for (int k = 0; k < 6; k++) begin
         drive_entry(k inside {0, 2, 3}, k inside {1, 5}, k == 3, 2'd3, $urandom(),
            $urandom());
         repeat (14) @(negedge clk);
      end
      wait_quiet();
      check_value("single event packets", rx_count - rx0, 4);
      check_value("drop count", reported_total, 0);

      // privilege changes with and without a jump
      rx0 = rx_count;
      drive_entry(1'b0, 1'b0, 1'b0, 2'd0, $urandom(), $urandom());
      repeat (14) @(negedge clk);
      drive_entry(1'b1, 1'b0, 1'b0, 2'd0, $urandom(), $urandom());
      repeat (14) @(negedge clk);
      drive_entry(1'b0, 1'b1, 1'b1, 2'd1, $urandom(), $urandom());
      wait_quiet();
      check_value("privilege packets", rx_count - rx0, 3);

      // back-to-back burst overflows the queue
      rx0 = rx_count;
      rep0 = reported_total;
      repeat (N_BURST) drive_entry(1'b1, 1'b0, 1'b0, prv_exp, $urandom(), $urandom());
      wait_quiet();
      check_value("burst packets plus drops", (rx_count - rx0) + (reported_total - rep0),
         N_BURST);

      repeat (N_RANDOM) begin
         p = ($urandom_range(0, 7) == 0) ? ctm_pkg::prv_t'($urandom_range(0, 3)) : prv_exp;
         drive_entry($urandom_range(0, 3) == 0, $urandom_range(0, 3) == 0,
            $urandom_range(0, 4) == 0, p, $urandom(), $urandom());
         repeat ($urandom_range(0, 10)) @(negedge clk);
      end
      wait_quiet();
      // whatever never arrived must be covered by a reported drop
      check_value("lost packets", skipped_total + (exp_q.size() - head), reported_total);
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule
